// File: src/gpu_isa_pkg.sv
// Instruction set constants for the GPU front end
// Opcode and funct3 codes, field widths and the raw word union with one view per format

package gpu_isa_pkg;

  localparam int opc_w = 7;
  localparam int f3_w  = 3;
  localparam int reg_w = 5;

  localparam logic [opc_w-1:0] opc_lui    = 7'b0110111;
  localparam logic [opc_w-1:0] opc_auipc  = 7'b0010111;
  localparam logic [opc_w-1:0] opc_jal    = 7'b1101111;
  localparam logic [opc_w-1:0] opc_jalr   = 7'b1100111;
  localparam logic [opc_w-1:0] opc_branch = 7'b1100011;
  localparam logic [opc_w-1:0] opc_load   = 7'b0000011;
  localparam logic [opc_w-1:0] opc_store  = 7'b0100011;
  localparam logic [opc_w-1:0] opc_arithi = 7'b0010011;
  localparam logic [opc_w-1:0] opc_arith  = 7'b0110011;
  localparam logic [opc_w-1:0] opc_nop    = 7'h0b;   // Custom-0 slot

  // Divergent branches, these drop the thread from the active set
  localparam logic [f3_w-1:0] f3_beqd = 3'b010;
  localparam logic [f3_w-1:0] f3_bned = 3'b011;

  // One 32-bit word, read in the layout of each base format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } raw_inst_u;

endpackage

// File: src/gpu_pipe_pkg.sv
// Sizes and register map of the GPU instruction front end
// Shared by the APB block, the pipeline stages and the top level

package gpu_pipe_pkg;

  localparam int num_warps  = 8;
  localparam int warp_w     = 3;
  localparam int addr_w     = 32;
  localparam int data_w     = 32;
  localparam int apb_addr_w = 8;

  localparam int ibuf_depth = 4;
  localparam int ibuf_ptr_w = $clog2(ibuf_depth);
  localparam int ibuf_cnt_w = $clog2(ibuf_depth + 1);
  // pc, warp, opcode, funct3, rd/rs1/rs2, imm
  localparam int ibuf_ent_w = addr_w + warp_w + 7 + 3 + 3 * 5 + data_w;

  localparam logic st_idle   = 1'b0;
  localparam logic st_update = 1'b1;

  localparam logic [apb_addr_w-1:0] reg_pc         = 8'h00;
  localparam logic [apb_addr_w-1:0] reg_warp       = 8'h04;
  localparam logic [apb_addr_w-1:0] reg_inst       = 8'h08;  // Write issues
  localparam logic [apb_addr_w-1:0] reg_status     = 8'h0C;  // Buffer count, read only
  localparam logic [apb_addr_w-1:0] reg_split_base = 8'h40;
  localparam logic [apb_addr_w-1:0] reg_split_end  = 8'h60;  // One word per warp below this

endpackage

// File: src/gpu_front_if.sv
// Internal links of the instruction front end
// fetch to decode, decode to split table, decode to instruction buffer

`timescale 1ns/1ns

interface fetch_decode_if import gpu_pipe_pkg::*, gpu_isa_pkg::*; ();
  logic              valid;  // One cycle per issued word
  logic              busy;   // Decode cannot take a word
  logic [addr_w-1:0] pc;
  logic [warp_w-1:0] warp;
  raw_inst_u         inst;

  modport src (output valid, pc, warp, inst, input busy);
  modport dst (input valid, pc, warp, inst, output busy);
endinterface

interface decode_split_if import gpu_pipe_pkg::*; ();
  logic              valid;
  logic [warp_w-1:0] warp;
  logic [addr_w-1:0] next_pc;
  logic              stall;
  logic              active;

  modport src (output valid, warp, next_pc, stall, active);
  modport dst (input valid, warp, next_pc, stall, active);
endinterface

interface decode_ibuf_if import gpu_pipe_pkg::*, gpu_isa_pkg::*; ();
  logic                  valid;  // Push strobe
  logic                  full;
  logic [ibuf_cnt_w-1:0] count;
  logic [addr_w-1:0]     pc;
  logic [warp_w-1:0]     warp;
  logic [opc_w-1:0]      opcode;
  logic [f3_w-1:0]       funct3;
  logic [reg_w-1:0]      rd;
  logic [reg_w-1:0]      rs1;
  logic [reg_w-1:0]      rs2;
  logic [data_w-1:0]     imm;

  modport src (
    output valid, pc, warp, opcode, funct3, rd, rs1, rs2, imm,
    input  full, count
  );
  modport dst (
    input  valid, pc, warp, opcode, funct3, rd, rs1, rs2, imm,
    output full, count
  );
endinterface

// File: src/inst_fetch_apb.sv
// APB slave standing in for instruction fetch
// Host writes pc and warp, then the word to reg_inst, which issues it to decode

`timescale 1ns/1ns

module inst_fetch_apb
  import gpu_pipe_pkg::*, gpu_isa_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [apb_addr_w-1:0] paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [data_w-1:0]     pwdata,
  output logic [data_w-1:0]     prdata,
  output logic                  pready,
  output logic                  pslverr,
  fetch_decode_if.src           fd,
  output logic [warp_w-1:0]     split_rd_warp,
  input  logic [data_w-1:0]     split_rd_data,
  input  logic [ibuf_cnt_w-1:0] ibuf_count
);

  logic [addr_w-1:0] pc_q;
  logic [warp_w-1:0] warp_q;
  logic access, wr_inst, issue, in_split, rd_hit;

  assign access  = psel && penable;
  assign wr_inst = access && pwrite && (paddr == reg_inst);
  // Hold the bus while decode still owns the previous word
  assign pready  = access && !(wr_inst && (fd.busy || fd.valid));
  assign issue   = wr_inst && pready;

  assign in_split      = (paddr >= reg_split_base) && (paddr < reg_split_end);
  assign split_rd_warp = paddr[warp_w+1:2];  // Word index inside the split window

  always_comb begin
    prdata = '0;
    rd_hit = 1'b1;
    if (in_split) begin
      prdata = split_rd_data;
    end else begin
      case (paddr)
        reg_pc:     prdata = pc_q;
        reg_warp:   prdata = data_w'(warp_q);
        reg_inst:   prdata = fd.inst;          // Last issued word
        reg_status: prdata = data_w'(ibuf_count);
        default:    rd_hit = 1'b0;
      endcase
    end
  end

  assign pslverr = access && !pwrite && !rd_hit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q   <= '0;
      warp_q <= '0;
    end else if (access && pwrite && pready) begin
      if (paddr == reg_pc) pc_q <= pwdata;
      if (paddr == reg_warp) warp_q <= pwdata[warp_w-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) fd.valid <= 1'b0;
    else fd.valid <= issue;  // Single-cycle strobe
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      fd.pc   <= pc_q;
      fd.warp <= warp_q;
      fd.inst <= raw_inst_u'(pwdata);
    end
  end

  // Decode must still be idle while an issued word is in flight
  a_issue_idle: assert property (@(posedge clk) disable iff (!rst_n) fd.valid |-> !fd.busy)
    else $error("fetch: word issued while decode busy");

endmodule

// File: src/inst_decode.sv
// Decode stage of the front end
// Takes one raw word per issue, splits it into fields and immediates,
// pushes it to the instruction buffer and updates the warp's split entry

`timescale 1ns/1ns

module inst_decode
  import gpu_pipe_pkg::*, gpu_isa_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  fetch_decode_if.dst fd,
  decode_split_if.src ds,
  decode_ibuf_if.src  di,
  output logic        illegal_inst
);

  logic state;

  // Fields of the incoming word
  logic [f3_w-1:0]   dec_funct3;
  logic [reg_w-1:0]  dec_rd, dec_rs1, dec_rs2;
  logic [data_w-1:0] dec_imm;
  logic              dec_legal;

  // Captured instruction
  logic [addr_w-1:0] pc_q;
  logic [warp_w-1:0] warp_q;
  logic [opc_w-1:0]  opcode_q;
  logic [f3_w-1:0]   funct3_q;
  logic [reg_w-1:0]  rd_q, rs1_q, rs2_q;
  logic [data_w-1:0] imm_q;
  logic              legal_q;
  logic              is_branch, is_jump;

  always_comb begin
    dec_funct3 = '0;
    dec_rd     = '0;
    dec_rs1    = '0;
    dec_rs2    = '0;
    dec_imm    = '0;
    dec_legal  = 1'b1;
    case (fd.inst.r.opcode)
      opc_lui, opc_auipc: begin
        dec_rd  = fd.inst.u.rd;
        dec_imm = {fd.inst.u.imm_31_12, 12'b0};
      end
      opc_jal: begin
        dec_rd  = fd.inst.j.rd;
        dec_imm = {{12{fd.inst.j.imm_20}}, fd.inst.j.imm_19_12, fd.inst.j.imm_11,
                   fd.inst.j.imm_10_1, 1'b0};
      end
      opc_jalr, opc_load, opc_arithi: begin  // All I-type
        dec_rd     = fd.inst.i.rd;
        dec_rs1    = fd.inst.i.rs1;
        dec_funct3 = fd.inst.i.funct3;
        dec_imm    = {{20{fd.inst.i.imm_11_0[11]}}, fd.inst.i.imm_11_0};
      end
      opc_branch: begin
        dec_rs1    = fd.inst.b.rs1;
        dec_rs2    = fd.inst.b.rs2;
        dec_funct3 = fd.inst.b.funct3;
        dec_imm    = {{20{fd.inst.b.imm_12}}, fd.inst.b.imm_11, fd.inst.b.imm_10_5,
                      fd.inst.b.imm_4_1, 1'b0};
      end
      opc_store: begin
        dec_rs1    = fd.inst.s.rs1;
        dec_rs2    = fd.inst.s.rs2;
        dec_funct3 = fd.inst.s.funct3;
        dec_imm    = {{20{fd.inst.s.imm_11_5[6]}}, fd.inst.s.imm_11_5, fd.inst.s.imm_4_0};
      end
      opc_arith: begin
        dec_rd     = fd.inst.r.rd;
        dec_rs1    = fd.inst.r.rs1;
        dec_rs2    = fd.inst.r.rs2;
        dec_funct3 = fd.inst.r.funct3;
      end
      opc_nop:  dec_legal = 1'b1;  // No fields
      default:  dec_legal = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
    end else if (state == st_idle) begin
      if (fd.valid) state <= st_update;
    end else if (!legal_q || !di.full) begin
      state <= st_idle;  // Illegal words leave without a push
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && fd.valid) begin
      pc_q     <= fd.pc;
      warp_q   <= fd.warp;
      opcode_q <= fd.inst.r.opcode;
      funct3_q <= dec_funct3;
      rd_q     <= dec_rd;
      rs1_q    <= dec_rs1;
      rs2_q    <= dec_rs2;
      imm_q    <= dec_imm;
      legal_q  <= dec_legal;
    end
  end

  assign fd.busy      = (state == st_update);
  assign illegal_inst = (state == st_update) && !legal_q;
  assign di.valid     = (state == st_update) && legal_q && !di.full;

  assign di.pc     = pc_q;
  assign di.warp   = warp_q;
  assign di.opcode = opcode_q;
  assign di.funct3 = funct3_q;
  assign di.rd     = rd_q;
  assign di.rs1    = rs1_q;
  assign di.rs2    = rs2_q;
  assign di.imm    = imm_q;

  // Split-table update goes out on the push edge
  assign is_branch  = (opcode_q == opc_branch);
  assign is_jump    = (opcode_q == opc_jal) || (opcode_q == opc_jalr);
  assign ds.valid   = di.valid;
  assign ds.warp    = warp_q;
  assign ds.stall   = (opcode_q == opc_auipc) || is_branch;
  assign ds.next_pc = is_jump ? pc_q + imm_q : pc_q + addr_w'(4);
  assign ds.active  = !(is_branch && (funct3_q == f3_beqd || funct3_q == f3_bned));

  // Buffer occupancy must leave room for every push
  a_push_room: assert property (@(posedge clk) disable iff (!rst_n)
    di.valid |-> di.count < ibuf_cnt_w'(ibuf_depth))
    else $error("decode: push into a full buffer, count %0d", di.count);

endmodule

// File: src/split_table.sv
// Per-warp split table
// Holds next pc, stall and active bit of every warp, written by decode,
// read back as one word with stall in bit 0 and active in bit 1

`timescale 1ns/1ns

module split_table
  import gpu_pipe_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  decode_split_if.dst       ds,
  input  logic [warp_w-1:0] rd_warp,
  output logic [data_w-1:0] rd_data
);

  logic [addr_w-1:0]    next_pc_q [num_warps];
  logic [num_warps-1:0] stall_q;
  logic [num_warps-1:0] active_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < num_warps; w++) begin
        next_pc_q[w] <= '0;
      end
      stall_q  <= '0;
      active_q <= '1;  // All threads start active
    end else if (ds.valid) begin
      next_pc_q[ds.warp] <= ds.next_pc;
      stall_q[ds.warp]   <= ds.stall;
      active_q[ds.warp]  <= ds.active;
    end
  end

  // Low two bits of the word-aligned pc carry the flags
  assign rd_data = {next_pc_q[rd_warp][addr_w-1:2], active_q[rd_warp], stall_q[rd_warp]};

  // Only a divergent branch drops a warp from the active set, and branches stall
  a_inactive_stalls: assert property (@(posedge clk) disable iff (!rst_n)
    ds.valid && !ds.active |-> ds.stall)
    else $error("split: warp %0d deactivated without a stall", $sampled(ds.warp));

endmodule

// File: src/inst_buffer.sv
// Instruction buffer between decode and the issue stage
// Circular FIFO of decoded instructions, popped on out_valid and out_ready

`timescale 1ns/1ns

module inst_buffer
  import gpu_pipe_pkg::*, gpu_isa_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  decode_ibuf_if.dst        di,
  output logic              out_valid,
  input  logic              out_ready,
  output logic [addr_w-1:0] out_pc,
  output logic [warp_w-1:0] out_warp,
  output logic [opc_w-1:0]  out_opcode,
  output logic [f3_w-1:0]   out_funct3,
  output logic [reg_w-1:0]  out_rd,
  output logic [reg_w-1:0]  out_rs1,
  output logic [reg_w-1:0]  out_rs2,
  output logic [data_w-1:0] out_imm
);

  logic [ibuf_ent_w-1:0] mem [ibuf_depth];
  logic [ibuf_ptr_w-1:0] wr_ptr, rd_ptr;
  logic [ibuf_cnt_w-1:0] count;
  logic                  pop;

  assign pop       = out_valid && out_ready;
  assign out_valid = (count != '0);
  assign di.count  = count;
  assign di.full   = (count == ibuf_cnt_w'(ibuf_depth));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (di.valid) wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      if (di.valid && !pop) count <= count + 1'b1;
      else if (pop && !di.valid) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (di.valid) begin
      mem[wr_ptr] <= {di.pc, di.warp, di.opcode, di.funct3, di.rd, di.rs1, di.rs2, di.imm};
    end
  end

  assign {out_pc, out_warp, out_opcode, out_funct3, out_rd, out_rs1, out_rs2, out_imm} =
    mem[rd_ptr];

  // A full buffer must not take an entry on that edge
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    di.full |=> wr_ptr == $past(wr_ptr))
    else $error("ibuf: write pointer moved while full");

endmodule

// File: src/gpu_frontend_top.sv
// Instruction front end of one SM core
// APB host side in, decoded instructions out on a valid/ready port

`timescale 1ns/1ns

module gpu_frontend_top
  import gpu_pipe_pkg::*, gpu_isa_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [apb_addr_w-1:0] paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [data_w-1:0]     pwdata,
  output logic [data_w-1:0]     prdata,
  output logic                  pready,
  output logic                  pslverr,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [addr_w-1:0]     out_pc,
  output logic [warp_w-1:0]     out_warp,
  output logic [opc_w-1:0]      out_opcode,
  output logic [f3_w-1:0]       out_funct3,
  output logic [reg_w-1:0]      out_rd,
  output logic [reg_w-1:0]      out_rs1,
  output logic [reg_w-1:0]      out_rs2,
  output logic [data_w-1:0]     out_imm,
  output logic                  illegal_inst
);

  fetch_decode_if fd_bus ();
  decode_split_if ds_bus ();
  decode_ibuf_if  di_bus ();

  logic [warp_w-1:0] split_rd_warp;
  logic [data_w-1:0] split_rd_data;

  inst_fetch_apb inst_fetch_apb_inst (
    .clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
    .fd            (fd_bus.src),
    .split_rd_warp (split_rd_warp),
    .split_rd_data (split_rd_data),
    .ibuf_count    (di_bus.count)
  );

  inst_decode inst_decode_inst (
    .clk, .rst_n,
    .fd           (fd_bus.dst),
    .ds           (ds_bus.src),
    .di           (di_bus.src),
    .illegal_inst (illegal_inst)
  );

  split_table split_table_inst (
    .clk, .rst_n,
    .ds      (ds_bus.dst),
    .rd_warp (split_rd_warp),
    .rd_data (split_rd_data)
  );

  inst_buffer inst_buffer_inst (
    .clk, .rst_n,
    .di (di_bus.dst),
    .out_valid, .out_ready, .out_pc, .out_warp, .out_opcode, .out_funct3,
    .out_rd, .out_rs1, .out_rs2, .out_imm
  );

endmodule

// File: tests/tb_gpu_frontend.sv
// Testbench for the GPU instruction front end
// Issues random instructions over APB and checks decoded output, split entries and status

`timescale 1ns/1ns

module tb_gpu_frontend import gpu_pipe_pkg::*, gpu_isa_pkg::*; ();

  localparam int n_insts    = 10 * 4 + 3 + 6;  // Decode, illegal and backpressure tests
  localparam int max_cycles = 40 * n_insts + 200;

  logic                  clk, rst_n;
  logic [apb_addr_w-1:0] paddr;
  logic                  psel, penable, pwrite, pready, pslverr;
  logic [data_w-1:0]     pwdata, prdata;
  logic                  out_valid, out_ready, illegal_inst;
  logic [addr_w-1:0]     out_pc;
  logic [warp_w-1:0]     out_warp;
  logic [opc_w-1:0]      out_opcode;
  logic [f3_w-1:0]       out_funct3;
  logic [reg_w-1:0]      out_rd, out_rs1, out_rs2;
  logic [data_w-1:0]     out_imm;

  // Reference model state
  logic [ibuf_ent_w-1:0] exp_q [$];
  logic [ibuf_ent_w-1:0] exp_head, got_ent;
  logic [data_w-1:0]     split_exp [num_warps];
  logic [data_w-1:0]     exp_rdata;
  logic                  exp_err, rd_check, illegal_armed, pop_due;
  logic [warp_w-1:0]     last_warp;
  int                    exp_cnt, errors, tests_passed, tests_failed, cycles, last_wait;
  int                    seed = 32'h40b3_0a42;

  logic [opc_w-1:0] legal_opcs [10] = '{opc_lui, opc_auipc, opc_jal, opc_jalr, opc_branch,
                                        opc_load, opc_store, opc_arithi, opc_arith, opc_nop};
  logic [opc_w-1:0] bad_opcs [3] = '{7'h00, 7'h2b, 7'h7f};
  string field_name [8] = '{"out_pc", "out_warp", "out_opcode", "out_funct3",
                            "out_rd", "out_rs1", "out_rs2", "out_imm"};
  int field_w [8] = '{addr_w, warp_w, opc_w, f3_w, reg_w, reg_w, reg_w, data_w};

  gpu_frontend_top gpu_frontend_top_inst (.*);

  assign got_ent = {out_pc, out_warp, out_opcode, out_funct3, out_rd, out_rs1, out_rs2, out_imm};

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout: run reached %0d cycles", max_cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // Queue head follows the output handshake half a cycle after the DUT edge
  always @(negedge clk) begin
    if (pop_due && exp_q.size() != 0) void'(exp_q.pop_front());
    pop_due  = out_valid && out_ready;  // Handshake on the coming edge
    exp_cnt  = exp_q.size();
    exp_head = (exp_cnt != 0) ? exp_q[0] : '0;
  end

  task automatic flag_wrong_value(input string name, input logic [data_w-1:0] got, exp);
    $display("mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    errors++;
  endtask

  task automatic fail_note(input string msg);
    $display("error: %s at %0t", msg, $time);
    errors++;
  endtask

  // Splits a popped entry into its fields and names each one that differs
  task automatic report_entry(input logic [ibuf_ent_w-1:0] got, exp);
    int lsb;
    int f;
    logic [ibuf_ent_w-1:0] mask;
    lsb = ibuf_ent_w;
    for (f = 0; f < 8; f++) begin
      lsb -= field_w[f];
      mask = ~({ibuf_ent_w{1'b1}} << field_w[f]);
      if (((got >> lsb) & mask) !== ((exp >> lsb) & mask))
        flag_wrong_value(field_name[f], data_w'((got >> lsb) & mask),
                         data_w'((exp >> lsb) & mask));
    end
  endtask

  a_pop_fields: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && out_ready |-> got_ent === exp_head)
    else report_entry($sampled(got_ent), $sampled(exp_head));
  a_pop_expected: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> exp_cnt > 0)
    else fail_note("out_valid high with no instruction outstanding");
  a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
    rd_check && psel && penable && pready && !exp_err |-> prdata === exp_rdata)
    else flag_wrong_value("prdata", $sampled(prdata), $sampled(exp_rdata));
  a_read_err: assert property (@(posedge clk) disable iff (!rst_n)
    rd_check && psel && penable && pready |-> pslverr === exp_err)
    else flag_wrong_value("pslverr", $sampled(pslverr), $sampled(exp_err));
  a_illegal_armed: assert property (@(posedge clk) disable iff (!rst_n)
    illegal_inst |-> illegal_armed)
    else fail_note("illegal_inst pulsed for a legal word");
  a_illegal_width: assert property (@(posedge clk) disable iff (!rst_n)
    illegal_inst |=> !illegal_inst)
    else fail_note("illegal_inst held longer than one cycle");

  // One APB transfer, setup phase then access until pready
  task automatic apb_access(input logic wr, input logic [apb_addr_w-1:0] addr,
                            input logic [data_w-1:0] data);
    @(posedge clk);
    #2;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #2 penable = 1'b1;
    last_wait = 0;
    @(negedge clk);
    while (!pready) begin
      last_wait++;
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [apb_addr_w-1:0] addr, input logic [data_w-1:0] data);
    apb_access(1'b1, addr, data);
  endtask

  task automatic apb_read(input logic [apb_addr_w-1:0] addr, input logic [data_w-1:0] exp,
                          input logic err);
    exp_rdata = exp;
    exp_err   = err;
    rd_check  = 1'b1;
    apb_access(1'b0, addr, '0);
    rd_check  = 1'b0;
  endtask

  function automatic logic [apb_addr_w-1:0] split_addr(input int w);
    return apb_addr_w'(reg_split_base + 4 * w);
  endfunction

  // Builds the word from randomly chosen fields and returns those fields
  task automatic encode_inst(input logic [opc_w-1:0] opc, input int rep,
                             output logic [data_w-1:0] word, output logic [f3_w-1:0] f3,
                             output logic [reg_w-1:0] rd, rs1, rs2,
                             output logic [data_w-1:0] imm);
    logic [31:0] fr, ir;
    fr = $random(seed);
    ir = $random(seed);
    {rd, rs1, rs2, f3} = fr[17:0];
    imm = '0;
    case (opc)
      opc_lui, opc_auipc: begin
        imm  = {ir[31:12], 12'b0};
        word = {imm[31:12], rd, opc};
        {rs1, rs2, f3} = '0;
      end
      opc_jal: begin
        imm  = {{11{ir[20]}}, ir[20:1], 1'b0};
        word = {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
        {rs1, rs2, f3} = '0;
      end
      opc_jalr, opc_load, opc_arithi: begin
        imm  = {{20{ir[11]}}, ir[11:0]};
        word = {imm[11:0], rs1, f3, rd, opc};
        rs2  = '0;
      end
      opc_store: begin
        imm  = {{20{ir[11]}}, ir[11:0]};
        word = {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
        rd   = '0;
      end
      opc_branch: begin
        f3   = f3_w'(rep + 1);  // Reps 1 and 2 give beqd and bned
        imm  = {{19{ir[12]}}, ir[12:1], 1'b0};
        word = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
        rd   = '0;
      end
      opc_arith: word = {ir[31:25], rs2, rs1, f3, rd, opc};
      default: begin  // nop and illegal codes carry no fields
        word = {ir[31:7], opc};
        {rd, rs1, rs2, f3} = '0;
      end
    endcase
  endtask

  // Picks pc and warp, records the expected result, then writes pc, warp and word
  task automatic issue(input logic [opc_w-1:0] opc, input int rep);
    logic [data_w-1:0] word, imm, pc, npc;
    logic [f3_w-1:0]   f3;
    logic [reg_w-1:0]  rd, rs1, rs2;
    logic [warp_w-1:0] warp;
    logic              stall, active;
    pc   = $random(seed) & 32'hffff_fffc;
    warp = warp_w'($random(seed));
    encode_inst(opc, rep, word, f3, rd, rs1, rs2, imm);
    if (opc inside {legal_opcs}) begin
      stall  = (opc == opc_auipc) || (opc == opc_branch);
      active = !(opc == opc_branch && (f3 == f3_beqd || f3 == f3_bned));
      npc    = (opc == opc_jal || opc == opc_jalr) ? pc + imm : pc + 32'd4;
      split_exp[warp] = {npc[31:2], active, stall};
      exp_q.push_back({pc, warp, opc, f3, rd, rs1, rs2, imm});
    end else begin
      illegal_armed = 1'b1;
    end
    last_warp = warp;
    apb_write(reg_pc, pc);
    apb_write(reg_warp, data_w'(warp));
    apb_write(reg_inst, word);
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 50) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) fail_note("buffer did not deliver every issued instruction");
  endtask

  task automatic wait_illegal();
    int n;
    n = 0;
    while (!illegal_inst && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!illegal_inst) fail_note("illegal_inst did not pulse for an illegal opcode");
    @(negedge clk);
    illegal_armed = 1'b0;
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail, %0d errors", name, errors - errs_before);
    end
  endtask

  initial begin
    int errs;
    int k;
    clk = 1'b0;
    rst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    out_ready = 1'b1;
    {rd_check, exp_err, illegal_armed, pop_due} = '0;
    exp_rdata = '0;
    last_warp = '0;
    {errors, tests_passed, tests_failed, cycles, last_wait} = '0;
    for (k = 0; k < num_warps; k++) split_exp[k] = 32'h2;  // pc zero, active set
    repeat (16) @(posedge clk);
    #2 rst_n = 1'b1;

    errs = errors;
    for (k = 0; k < num_warps; k++) apb_read(split_addr(k), split_exp[k], 1'b0);
    apb_read(8'h20, '0, 1'b1);  // Hole between status and split window
    end_test("reset state", errs);

    errs = errors;
    foreach (legal_opcs[o]) begin
      for (k = 0; k < 4; k++) begin
        issue(legal_opcs[o], k);
        wait_drain();
        apb_read(split_addr(last_warp), split_exp[last_warp], 1'b0);
      end
    end
    end_test("decode and split update", errs);

    errs = errors;
    foreach (bad_opcs[o]) begin
      issue(bad_opcs[o], 0);
      wait_illegal();
      apb_read(split_addr(last_warp), split_exp[last_warp], 1'b0);
    end
    end_test("illegal opcode", errs);

    // Fill the buffer plus one held in decode, then stall the next write
    errs = errors;
    out_ready = 1'b0;
    for (k = 0; k < ibuf_depth + 1; k++) issue(legal_opcs[$unsigned($random(seed)) % 10], 0);
    apb_read(reg_status, data_w'(ibuf_depth), 1'b0);
    fork
      issue(legal_opcs[$unsigned($random(seed)) % 10], 0);
      begin
        repeat (12) @(posedge clk);
        #2 out_ready = 1'b1;
      end
    join
    if (last_wait == 0) fail_note("pready not held low while decode waited on a full buffer");
    wait_drain();
    apb_read(reg_status, '0, 1'b0);
    end_test("buffer backpressure", errs);

    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: sources.f
src/gpu_isa_pkg.sv
src/gpu_pipe_pkg.sv
src/gpu_front_if.sv
src/inst_fetch_apb.sv
src/inst_decode.sv
src/split_table.sv
src/inst_buffer.sv
src/gpu_frontend_top.sv
tests/tb_gpu_frontend.sv
